/* hw/stringReaderPkg.sv */
package stringReaderPkg;

	typedef logic [511:0] lineData_t;   // one cache line
	typedef logic [57:0]  lineAddr_t;   // byte base or line index
	typedef logic [31:0]  heapOffset_t; // byte offset into the heap
	typedef logic [31:0]  strCount_t;
	typedef logic [3:0]   wordIdx_t;    // 32-bit word within a line
	typedef logic [15:0]  lineCount_t;

	localparam int LINE_BYTES       = 64;
	localparam int OFFSETS_PER_LINE = 16;

	// tag 0 is an offset line, tag 1 a heap line
	typedef struct packed {
		lineAddr_t addr;
		logic      tag;
	} memReq_t;

	typedef struct packed {
		lineData_t data;
		logic      tag;
	} memResp_t;

	// per string, consumed by the aligner
	typedef struct packed {
		wordIdx_t   startWord;
		lineCount_t beats;     // lines spanned by the string
		logic       first;     // next line only fills the window
	} stringMeta_t;

	typedef struct packed {
		lineData_t data;
		logic      last;
	} outBeat_t;

	typedef enum logic [2:0] {
		IDLE, READ_OFFSETS, WAIT_OFFSETS, LOAD_LINE, STRING_HEAD, STRING_BODY, FINISHED
	} seqState_t;

endpackage

/* hw/lineFifo.sv */
`timescale 1ns/1ps

module lineFifo #(
	parameter int Width            = 512,
	parameter int DepthLog         = 5,
	parameter int AlmostFullMargin = 4
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic [Width-1:0] pushData,
	input  logic             pop,
	output logic [Width-1:0] popData,
	output logic             empty,
	output logic             almostFull
);

	localparam int Depth = 1 << DepthLog;
	localparam logic [DepthLog:0] FullLevel = (DepthLog + 1)'(Depth - AlmostFullMargin);

	logic [Width-1:0]    mem [Depth];
	logic [DepthLog-1:0] wrPtr;
	logic [DepthLog-1:0] rdPtr;
	logic [DepthLog:0]   count;  // one bit wider than the pointers
	logic                doPush;
	logic                doPop;

	assign doPush = push && (count != (DepthLog + 1)'(Depth)); // drop on full
	assign doPop  = pop && !empty;

	assign empty      = (count == '0);
	assign almostFull = (count >= FullLevel);
	assign popData    = mem[rdPtr]; // show-ahead head

	always_ff @(posedge clk) begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			// simultaneous push and pop leaves count unchanged
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

endmodule

/* hw/offsetLoader.sv */
`timescale 1ns/1ps

module offsetLoader #(
	parameter int OffsetDepthLog   = 5,
	parameter int AlmostFullMargin = 4
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        start,
	input  stringReaderPkg::lineCount_t lineTotal,
	input  logic                        respValid,
	input  stringReaderPkg::memResp_t   resp,
	input  logic                        offsetPop,
	output stringReaderPkg::lineData_t  offsetLine,
	output logic                        offsetEmpty,
	output logic                        offsetsLoaded
);
	import stringReaderPkg::*;

	logic       linePush;  // registered offset response
	lineData_t  lineReg;
	lineCount_t lineCount; // lines written this run

	always_ff @(posedge clk) begin
		lineReg <= resp.data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			linePush  <= 1'b0;
			lineCount <= '0;
		end else begin
			linePush <= respValid && !resp.tag; // offset lines only
			if (start)
				lineCount <= '0;
			else if (linePush)
				lineCount <= lineCount + 1'b1;
		end
	end

	// count moves on the same edge as the fifo write
	assign offsetsLoaded = (lineCount == lineTotal);

	lineFifo #(
		.Width           ($bits(lineData_t)),
		.DepthLog        (OffsetDepthLog),
		.AlmostFullMargin(AlmostFullMargin)
	) offsetFifo (
		.clk       (clk),
		.rst       (rst),
		.push      (linePush),
		.pushData  (lineReg),
		.pop       (offsetPop),
		.popData   (offsetLine),
		.empty     (offsetEmpty),
		.almostFull()            // sized so all offset lines fit
	);

endmodule

/* hw/requestSequencer.sv */
`timescale 1ns/1ps

module requestSequencer (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         go,
	input  stringReaderPkg::lineAddr_t   baseAddr,
	input  stringReaderPkg::lineAddr_t   heapAddr,
	input  stringReaderPkg::strCount_t   batCount,
	output logic                         memReqValid,
	input  logic                         memReqReady,
	output stringReaderPkg::memReq_t     memReq,
	input  logic                         offsetsLoaded,
	input  stringReaderPkg::lineData_t   offsetLine,
	input  logic                         offsetEmpty,
	output logic                         offsetPop,
	output logic                         metaPush,
	output stringReaderPkg::stringMeta_t meta,
	input  logic                         metaAlmostFull,
	input  logic                         outAlmostFull,
	output stringReaderPkg::lineCount_t  lineTotal,
	output logic                         start
);
	import stringReaderPkg::*;

	seqState_t   state;
	lineAddr_t   heapLine;  // heap base as line index
	strCount_t   strTotal;
	strCount_t   strIdx;
	lineCount_t  reqCount;  // offset lines requested
	lineCount_t  reqLeft;   // heap lines still to request for this string
	lineData_t   curLine;   // offsets of the current line
	wordIdx_t    word;      // offset i mod 16
	wordIdx_t    nextWord;
	heapOffset_t startOff;
	heapOffset_t endOff;
	heapOffset_t lastOff;
	lineCount_t  spanLines;
	logic        stall;
	logic        reqTaken;

	assign stall    = metaAlmostFull || outAlmostFull;
	assign reqTaken = memReqValid && memReqReady;
	assign start    = go && (state == IDLE || state == FINISHED);

	// pop on line change, and drain the unused tail line at the end
	assign offsetPop = (state == LOAD_LINE || state == FINISHED) && !offsetEmpty;

	// end of string i is offset i+1, found in the fifo head at word 15
	assign nextWord = word + 1'b1;
	assign startOff = curLine[32*word +: 32];
	assign endOff   = (word == 4'd15) ? offsetLine[31:0] : curLine[32*nextWord +: 32];
	assign lastOff  = (endOff > startOff) ? endOff - 1'b1 : startOff; // empty string -> 1 line
	assign spanLines = lineCount_t'((lastOff >> 6) - (startOff >> 6) + 1'b1);

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= IDLE;
			memReqValid <= 1'b0;
			metaPush    <= 1'b0;
			lineTotal   <= '0;
			reqCount    <= '0;
			reqLeft     <= '0;
			strIdx      <= '0;
			word        <= '0;
		end else begin
			metaPush <= 1'b0;
			case (state)
				IDLE, FINISHED: begin
					if (go) begin
						heapLine  <= lineAddr_t'(heapAddr >> 6);
						strTotal  <= batCount;
						// batCount+1 offsets, whole lines
						lineTotal <= lineCount_t'((batCount + strCount_t'(OFFSETS_PER_LINE))
							/ OFFSETS_PER_LINE);
						memReq.addr <= lineAddr_t'(baseAddr >> 6);
						memReq.tag  <= 1'b0;
						memReqValid <= 1'b1;
						reqCount    <= '0;
						strIdx      <= '0;
						word        <= '0;
						state       <= READ_OFFSETS;
					end
				end
				READ_OFFSETS: begin
					if (reqTaken) begin
						reqCount    <= reqCount + 1'b1;
						memReq.addr <= memReq.addr + 1'b1;
						if (reqCount + 16'd1 == lineTotal) begin
							memReqValid <= 1'b0;
							state       <= WAIT_OFFSETS;
						end
					end
				end
				WAIT_OFFSETS: begin
					if (offsetsLoaded)
						state <= (strTotal == '0) ? FINISHED : LOAD_LINE;
				end
				LOAD_LINE: begin
					if (!offsetEmpty) begin
						curLine <= offsetLine;
						state   <= STRING_HEAD;
					end
				end
				STRING_HEAD: begin
					if (!stall) begin
						meta.startWord <= startOff[5:2];  // 4-byte granularity
						meta.beats     <= spanLines;
						meta.first     <= 1'b1;
						metaPush       <= 1'b1;
						memReq.addr    <= heapLine + lineAddr_t'(startOff >> 6);
						memReq.tag     <= 1'b1;
						memReqValid    <= 1'b1;
						reqLeft        <= spanLines;      // plus the line after the last
						state          <= STRING_BODY;
					end
				end
				STRING_BODY: begin
					if (reqTaken) begin
						if (reqLeft == '0) begin
							memReqValid <= 1'b0;
							strIdx      <= strIdx + 1'b1;
							word        <= nextWord;
							if (strIdx + 32'd1 == strTotal)
								state <= FINISHED;
							else if (word == 4'd15)
								state <= LOAD_LINE;    // next offset line
							else
								state <= STRING_HEAD;
						end else begin
							memReq.addr <= memReq.addr + 1'b1;
							reqLeft     <= reqLeft - 1'b1;
							memReqValid <= !stall; // pause between lines
						end
					end else if (!memReqValid && !stall) begin
						memReqValid <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

/* hw/wordAligner.sv */
`timescale 1ns/1ps

module wordAligner #(
	parameter int MetaDepthLog     = 5,
	parameter int AlmostFullMargin = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         respValid,
	input  stringReaderPkg::memResp_t    resp,
	input  logic                         metaPush,
	input  stringReaderPkg::stringMeta_t meta,
	output logic                         metaAlmostFull,
	output logic                         beatValid,
	output stringReaderPkg::outBeat_t    beat
);
	import stringReaderPkg::*;

	localparam int WinBits = 2 * $bits(lineData_t);

	stringMeta_t         metaHead;
	stringMeta_t         curMeta;   // beats counts down the remaining beats
	stringMeta_t         src;
	logic                metaEmpty;
	logic                metaPop;
	logic                haveMeta;
	logic                heapResp;
	lineData_t           prevLine;
	logic                winValid;  // stage 1
	logic                winLast;
	wordIdx_t            winShift;
	logic [WinBits-1:0]  window;    // next line above previous line
	logic [WinBits-1:0]  shifted;

	assign heapResp = respValid && resp.tag;
	assign src      = haveMeta ? curMeta : metaHead;
	assign metaPop  = heapResp && !haveMeta && !metaEmpty; // one pop per string
	assign shifted  = window >> {winShift, 5'd0};

	lineFifo #(
		.Width           ($bits(stringMeta_t)),
		.DepthLog        (MetaDepthLog),
		.AlmostFullMargin(AlmostFullMargin)
	) metaFifo (
		.clk       (clk),
		.rst       (rst),
		.push      (metaPush),
		.pushData  (meta),
		.pop       (metaPop),
		.popData   (metaHead),
		.empty     (metaEmpty),
		.almostFull(metaAlmostFull)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			haveMeta  <= 1'b0;
			winValid  <= 1'b0;
			beatValid <= 1'b0;
		end else begin
			winValid  <= heapResp && !src.first; // first line only fills
			beatValid <= winValid;
			if (heapResp) begin
				if (src.first)
					haveMeta <= 1'b1;
				else if (src.beats == 16'd1)
					haveMeta <= 1'b0; // string done
			end
		end
	end

	always_ff @(posedge clk) begin
		if (heapResp) begin
			prevLine          <= resp.data;
			window            <= {resp.data, prevLine};
			winShift          <= src.startWord;
			winLast           <= (src.beats == 16'd1) && !src.first;
			curMeta.startWord <= src.startWord;
			curMeta.beats     <= src.first ? src.beats : src.beats - 1'b1;
			curMeta.first     <= 1'b0;
		end
		beat.data <= shifted[$bits(lineData_t)-1:0];
		beat.last <= winLast;
	end

endmodule

/* hw/streamOutput.sv */
`timescale 1ns/1ps

module streamOutput #(
	parameter int OutDepthLog      = 5,
	parameter int AlmostFullMargin = 4
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       start,
	input  stringReaderPkg::strCount_t batCount,
	input  logic                       beatValid,
	input  stringReaderPkg::outBeat_t  beat,
	output logic                       outAlmostFull,
	output logic                       stringValid,
	input  logic                       stringReady,
	output stringReaderPkg::outBeat_t  stringBeat,
	output logic                       done
);
	import stringReaderPkg::*;

	logic      fifoEmpty;
	logic      accept;
	logic      running;   // low until the first go
	strCount_t target;    // strings expected this run
	strCount_t lastCount; // last beats accepted

	assign stringValid = !fifoEmpty; // head holds while ready is low
	assign accept      = stringValid && stringReady;

	// extra margin for the two aligner stages still in flight
	lineFifo #(
		.Width           ($bits(outBeat_t)),
		.DepthLog        (OutDepthLog),
		.AlmostFullMargin(AlmostFullMargin + 2)
	) outFifo (
		.clk       (clk),
		.rst       (rst),
		.push      (beatValid),
		.pushData  (beat),
		.pop       (accept),
		.popData   (stringBeat),
		.empty     (fifoEmpty),
		.almostFull(outAlmostFull)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			running   <= 1'b0;
			done      <= 1'b0;
			lastCount <= '0;
		end else if (start) begin
			running   <= 1'b1;
			done      <= 1'b0;
			lastCount <= '0;
			target    <= batCount;
		end else begin
			if (accept && stringBeat.last)
				lastCount <= lastCount + 1'b1;
			done <= running && (lastCount == target); // holds until next go
		end
	end

endmodule

/* hw/stringReader.sv */
`timescale 1ns/1ps

module stringReader #(
	parameter int OffsetDepthLog   = 5,
	parameter int MetaDepthLog     = 5,
	parameter int OutDepthLog      = 5,
	parameter int AlmostFullMargin = 4
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       go,
	input  stringReaderPkg::lineAddr_t baseAddr,  // offset array, byte address
	input  stringReaderPkg::lineAddr_t heapAddr,  // string heap, byte address
	input  stringReaderPkg::strCount_t batCount,
	output logic                       memReqValid,
	input  logic                       memReqReady,
	output stringReaderPkg::memReq_t   memReq,
	input  logic                       respValid,
	input  stringReaderPkg::memResp_t  resp,
	output logic                       stringValid,
	input  logic                       stringReady,
	output stringReaderPkg::outBeat_t  stringBeat,
	output logic                       done
);
	import stringReaderPkg::*;

	logic        start;
	lineCount_t  lineTotal;
	logic        offsetPop;
	lineData_t   offsetLine;
	logic        offsetEmpty;
	logic        offsetsLoaded;
	logic        metaPush;
	stringMeta_t meta;
	logic        metaAlmostFull;
	logic        outAlmostFull;
	logic        beatValid;
	outBeat_t    beat;

	offsetLoader #(
		.OffsetDepthLog  (OffsetDepthLog),
		.AlmostFullMargin(AlmostFullMargin)
	) loader (
		.clk(clk), .rst(rst), .start(start), .lineTotal(lineTotal),
		.respValid(respValid), .resp(resp), .offsetPop(offsetPop),
		.offsetLine(offsetLine), .offsetEmpty(offsetEmpty), .offsetsLoaded(offsetsLoaded)
	);

	requestSequencer sequencer (
		.clk(clk), .rst(rst), .go(go), .baseAddr(baseAddr), .heapAddr(heapAddr),
		.batCount(batCount), .memReqValid(memReqValid), .memReqReady(memReqReady),
		.memReq(memReq), .offsetsLoaded(offsetsLoaded), .offsetLine(offsetLine),
		.offsetEmpty(offsetEmpty), .offsetPop(offsetPop), .metaPush(metaPush),
		.meta(meta), .metaAlmostFull(metaAlmostFull), .outAlmostFull(outAlmostFull),
		.lineTotal(lineTotal), .start(start)
	);

	wordAligner #(
		.MetaDepthLog    (MetaDepthLog),
		.AlmostFullMargin(AlmostFullMargin)
	) aligner (
		.clk(clk), .rst(rst), .respValid(respValid), .resp(resp),
		.metaPush(metaPush), .meta(meta), .metaAlmostFull(metaAlmostFull),
		.beatValid(beatValid), .beat(beat)
	);

	streamOutput #(
		.OutDepthLog     (OutDepthLog),
		.AlmostFullMargin(AlmostFullMargin)
	) outStage (
		.clk(clk), .rst(rst), .start(start), .batCount(batCount),
		.beatValid(beatValid), .beat(beat), .outAlmostFull(outAlmostFull),
		.stringValid(stringValid), .stringReady(stringReady),
		.stringBeat(stringBeat), .done(done)
	);

endmodule

/* dv/stringReader_properties.sv */
`timescale 1ns/1ps

module stringReaderProperties (
	input logic                      clk,
	input logic                      rst,
	input logic                      go,
	input logic                      memReqValid,
	input logic                      memReqReady,
	input stringReaderPkg::memReq_t  memReq,
	input logic                      stringValid,
	input logic                      stringReady,
	input stringReaderPkg::outBeat_t stringBeat,
	input logic                      done
);

	int failCount = 0; // read back at the end of the run

	// request stays up with a frozen address until taken
	reqHeld: assert property (@(posedge clk) disable iff (rst)
		memReqValid && !memReqReady |=> memReqValid && $stable(memReq))
	else begin
		failCount++;
		$error("memReq dropped or changed while memReqReady was low");
	end

	// stalled beat keeps valid and data
	beatHeld: assert property (@(posedge clk) disable iff (rst)
		stringValid && !stringReady |=> stringValid && $stable(stringBeat))
	else begin
		failCount++;
		$error("stringBeat dropped or changed while stringReady was low");
	end

	quietAfterReset: assert property (@(posedge clk)
		rst |=> !memReqValid && !stringValid && !done)
	else begin
		failCount++;
		$error("outputs active right after reset");
	end

	// done is a level until the next go
	doneHeld: assert property (@(posedge clk) disable iff (rst)
		done && !go |=> done)
	else begin
		failCount++;
		$error("done fell without a go");
	end

endmodule

/* dv/stringReaderChecker.sv */
`timescale 1ns/1ps

module stringReaderChecker #(
	parameter int MaxBeats = 1024
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      go,
	input  stringReaderPkg::outBeat_t expBeats [MaxBeats],
	input  int                        expTotal,
	input  int                        testId,
	input  logic                      stringValid,
	input  logic                      stringReady,
	input  stringReaderPkg::outBeat_t stringBeat,
	input  logic                      done,
	output int                        testsRun,
	output int                        testsFailed,
	output int                        beatCount,
	output int                        errorCount
);

	int   idx;        // next expected beat
	int   testErrors;
	logic running;    // a column is being read

	always @(posedge clk) begin
		if (rst) begin
			running     = 1'b0;
			idx         = 0;
			testErrors  = 0;
			testsRun    = 0;
			testsFailed = 0;
			beatCount   = 0;
			errorCount  = 0;
		end else if (go) begin
			idx        = 0;
			testErrors = 0;
			running    = 1'b1;
		end else begin
			if (stringValid && stringReady) begin
				beatCount++;
				if (!running) begin
					$display("beat accepted while no column was being read");
					errorCount++;
				end else if (idx >= expTotal) begin
					$display("test %0d: extra beat beyond the %0d expected", testId, expTotal);
					testErrors++;
				end else begin
					if (stringBeat.data !== expBeats[idx].data) begin
						$display("error: stringBeat.data test %0d beat %0d got %h expected %h",
							testId, idx, stringBeat.data, expBeats[idx].data);
						testErrors++;
					end
					if (stringBeat.last !== expBeats[idx].last) begin
						$display("error: stringBeat.last test %0d beat %0d got %h expected %h",
							testId, idx, stringBeat.last, expBeats[idx].last);
						testErrors++;
					end
				end
				idx++;
			end
			if (running && done) begin
				// every beat must be in before done
				if (idx != expTotal) begin
					$display("test %0d: done rose after %0d of %0d beats", testId, idx, expTotal);
					testErrors++;
				end
				$display("test %0d: %0d beats checked, %0d mismatches", testId, idx, testErrors);
				testsRun++;
				if (testErrors != 0)
					testsFailed++;
				errorCount += testErrors;
				running = 1'b0;
			end
		end
	end

endmodule

/* dv/stringReaderTb.sv */
`timescale 1ns/1ps

module stringReaderTb;
	import stringReaderPkg::*;

	localparam int MaxBeats   = 1024;
	localparam int MaxStrings = 64;
	localparam int MemBytes   = 65536;
	localparam int Timeout    = 20000; // cycles per column

	logic        clk;
	logic        rst;
	logic        go;
	lineAddr_t   baseAddr;
	lineAddr_t   heapAddr;
	strCount_t   batCount;
	logic        memReqValid;
	logic        memReqReady = 1'b0;
	memReq_t     memReq;
	logic        respValid = 1'b0;
	memResp_t    resp = '0;
	logic        stringValid;
	logic        stringReady = 1'b0;
	outBeat_t    stringBeat;
	logic        done;

	logic [7:0]  memBytes [MemBytes];
	heapOffset_t offs [MaxStrings+1];
	outBeat_t    expBeats [MaxBeats];
	int          expTotal = 0;
	int          testId = 0;
	int          readyMode = 0;      // 0 always, 1 random, 2 long stalls
	int          colSeed = 32'h8821;
	int          busSeed = 32'h8821; // bus side, own sequence
	int          stallLeft = 0;
	int          outstanding = 0;
	int          badRequests = 0;
	longint      cycle = 0;
	longint      lastDue = 0;
	memReq_t     pendQ [$];
	longint      dueQ [$];            // response cycle per request
	int          testsRun;
	int          testsFailed;
	int          beatCount;
	int          errorCount;

	stringReader #(
		.OffsetDepthLog  (5),
		.MetaDepthLog    (5),
		.OutDepthLog     (5),
		.AlmostFullMargin(4)
	) dut (
		.clk(clk), .rst(rst), .go(go), .baseAddr(baseAddr), .heapAddr(heapAddr),
		.batCount(batCount), .memReqValid(memReqValid), .memReqReady(memReqReady),
		.memReq(memReq), .respValid(respValid), .resp(resp), .stringValid(stringValid),
		.stringReady(stringReady), .stringBeat(stringBeat), .done(done)
	);

	stringReaderChecker #(.MaxBeats(MaxBeats)) beatCheck (
		.clk(clk), .rst(rst), .go(go), .expBeats(expBeats), .expTotal(expTotal),
		.testId(testId), .stringValid(stringValid), .stringReady(stringReady),
		.stringBeat(stringBeat), .done(done), .testsRun(testsRun),
		.testsFailed(testsFailed), .beatCount(beatCount), .errorCount(errorCount)
	);

	bind stringReader stringReaderProperties props (
		.clk(clk), .rst(rst), .go(go), .memReqValid(memReqValid), .memReqReady(memReqReady),
		.memReq(memReq), .stringValid(stringValid), .stringReady(stringReady),
		.stringBeat(stringBeat), .done(done)
	);

	// odd multiplier spreads every address bit into the top byte
	function automatic logic [7:0] fillByte(input int addr);
		logic [31:0] h;
		h = addr * 32'h9e3779b1;
		return h[31:24] ^ h[7:0];
	endfunction

	function automatic lineData_t readLine(input lineAddr_t line);
		lineData_t data;
		int        base;
		base = int'(line[19:0]) * LINE_BYTES;
		for (int b = 0; b < LINE_BYTES; b++)
			data[8*b +: 8] = memBytes[(base + b) % MemBytes]; // byte 0 in the low bits
		return data;
	endfunction

	// beat k of string i: 64 bytes from heap + offs[i] rounded down to 4, plus 64k
	function automatic void refBeats(input lineAddr_t heap, input int count);
		int first;
		int lastByte;
		int beats;
		int start;
		expTotal = 0;
		for (int i = 0; i < count; i++) begin
			first    = int'(offs[i]);
			lastByte = int'(offs[i+1]) - 1;
			beats    = lastByte / LINE_BYTES - first / LINE_BYTES + 1; // lines spanned
			for (int k = 0; k < beats; k++) begin
				start = int'(heap[19:0]) + (first & ~3) + LINE_BYTES * k;
				for (int b = 0; b < LINE_BYTES; b++)
					expBeats[expTotal].data[8*b +: 8] = memBytes[(start + b) % MemBytes];
				expBeats[expTotal].last = (k == beats - 1);
				expTotal++;
			end
		end
	endfunction

	// count+1 offsets, lengths 1..maxLen, optionally kept inside one line
	task automatic buildColumn(input lineAddr_t base, input int count, input int firstOff,
		input int maxLen, input bit fitLine);
		int pos;
		int len;
		int at;
		pos = firstOff;
		for (int i = 0; i <= count; i++) begin
			offs[i] = heapOffset_t'(pos);
			at = int'(base[19:0]) + 4 * i;
			for (int b = 0; b < 4; b++)
				memBytes[at + b] = 8'(pos >> (8 * b)); // little endian
			len = 1 + int'($unsigned($random(colSeed)) % maxLen);
			if (fitLine && len > LINE_BYTES - pos % LINE_BYTES)
				len = LINE_BYTES - pos % LINE_BYTES;
			pos += len;
		end
	endtask

	task automatic runColumn(input lineAddr_t base, input lineAddr_t heap, input int count,
		input int firstOff, input int maxLen, input bit fitLine, input int mode);
		int waited;
		buildColumn(base, count, firstOff, maxLen, fitLine);
		refBeats(heap, count);
		readyMode = mode;
		testId++;
		baseAddr = base;
		heapAddr = heap;
		batCount = strCount_t'(count);
		go = 1'b1;
		@(negedge clk);
		go = 1'b0;
		waited = 0;
		while (testsRun < testId && waited < Timeout) begin // checker sees done
			@(negedge clk);
			waited++;
		end
		if (testsRun < testId) begin
			$display("timeout: column %0d did not raise done in %0d cycles", testId, Timeout);
			$display("Test FAILED");
			$finish;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memory model and stream ready
	always @(negedge clk) begin
		memReq_t req;
		longint  due;
		cycle++;
		respValid = 1'b0; // single-cycle strobe
		if (!rst) begin
			if (dueQ.size() > 0 && dueQ[0] <= cycle) begin
				req = pendQ.pop_front();
				due = dueQ.pop_front();
				resp.data = readLine(req.addr);
				resp.tag  = req.tag;
				respValid = 1'b1;
				outstanding--;
			end
			memReqReady = (($random(busSeed) & 3) != 0) && (outstanding < 4);
			if (memReqValid && memReqReady) begin // taken at the next rising edge
				if (memReq.addr >= lineAddr_t'(MemBytes / LINE_BYTES)) begin
					$display("memory request for line %h is outside the model", memReq.addr);
					badRequests++;
				end
				due = cycle + 1 + longint'($unsigned($random(busSeed)) % 6);
				if (due <= lastDue)
					due = lastDue + 1; // keep request order
				lastDue = due;
				pendQ.push_back(memReq);
				dueQ.push_back(due);
				outstanding++;
			end
			case (readyMode)
				0: stringReady = 1'b1;
				1: stringReady = (($random(busSeed) & 1) != 0);
				default: begin
					if (stallLeft > 0) begin
						stringReady = 1'b0;
						stallLeft--;
					end else if (($random(busSeed) & 15) == 0) begin
						stallLeft   = 20 + int'($unsigned($random(busSeed)) % 40);
						stringReady = 1'b0;
					end else begin
						stringReady = (($random(busSeed) & 1) != 0);
					end
				end
			endcase
		end
	end

	initial begin
		rst      = 1'b1;
		go       = 1'b0;
		baseAddr = '0;
		heapAddr = '0;
		batCount = '0;
		for (int a = 0; a < MemBytes; a++)
			memBytes[a] = fillByte(a);
		repeat (5) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		runColumn(58'h0400, 58'h1000, 12, 0, 12, 1'b1, 0);   // one-line strings
		runColumn(58'h0400, 58'h1000, 10, 7, 200, 1'b0, 1);  // long, unaligned
		runColumn(58'h0400, 58'h2000, 40, 3, 100, 1'b0, 1);  // three offset lines
		runColumn(58'h0600, 58'h4000, 40, 0, 150, 1'b0, 2);  // long stalls
		runColumn(58'h0800, 58'h8000, 24, 130, 120, 1'b0, 0); // fresh bases
		repeat (4) @(negedge clk);
		$display("columns %0d, failed %0d, beats %0d, errors %0d, assertion failures %0d",
			testsRun, testsFailed, beatCount, errorCount, dut.props.failCount);
		if (testsFailed == 0 && errorCount == 0 && badRequests == 0
			&& dut.props.failCount == 0 && testsRun == testId)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* list.f */
hw/stringReaderPkg.sv
hw/lineFifo.sv
hw/offsetLoader.sv
hw/requestSequencer.sv
hw/wordAligner.sv
hw/streamOutput.sv
hw/stringReader.sv
dv/stringReader_properties.sv
dv/stringReaderChecker.sv
dv/stringReaderTb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --assert -Wno-fatal
TOP      := stringReaderTb
FILELIST := list.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
PASS     := Test OK
RUNARGS  := +verilator+error+limit+1000
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) $(RUNARGS) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
